//--- files.f
+incdir+src
src/cpu_pkg.sv
src/alu.sv
src/register_file.sv
src/instr_decoder.sv
src/bus_wb8.sv
src/cpu_control.sv
src/cpu.sv
tests/cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       ?= cpu_tb
FILELIST  ?= files.f
PASS_MSG  := Done: no errors

OBJ_DIR := obj_dir
SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard src/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_tb;

    localparam int MEM_SIZE   = 4096;
    localparam int RESULTS    = 'h200;     // where programs store their results
    localparam int MARKER     = 'h3f0;     // last store of every program
    localparam int RUN_LIMIT  = 20000;
    localparam int OPC_LOAD   = 'h03;
    localparam int OPC_OP_IMM = 'h13;
    localparam int OPC_AUIPC  = 'h17;
    localparam int OPC_LUI    = 'h37;
    localparam int OPC_JALR   = 'h67;

    logic                  clk = 1'b0;
    logic                  reset = 1'b1;
    logic                  wb_ack = 1'b0;
    logic [`CPU_BUS_W-1:0] wb_dat_i = '0;
    cpu_pkg::wb_master_t   wb_master;

    logic [7:0]  mem [MEM_SIZE];
    logic [31:0] prog [$];
    logic [31:0] first_adr [$];
    logic        first_we [$];
    logic [31:0] lfsr = 32'd87683;
    logic        marker_hit = 1'b0;
    int          wait_cnt = 0;
    int          errors = 0;
    int          timeouts = 0;

    // op order add sub sll slt sltu xor srl sra or and
    int op_f3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
    bit op_alt [10] = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};

    cpu dut_i (
        .clk       (clk),
        .reset     (reset),
        .wb_master (wb_master),
        .wb_ack    (wb_ack),
        .wb_dat_i  (wb_dat_i)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32 + x^22 + x^2 + x + 1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // byte slave with 0 to 3 wait cycles before ack
    always @(negedge clk) begin
        if (reset) begin
            wb_ack   = 1'b0;
            wait_cnt = 0;
        end else if (wb_ack) begin
            wb_ack   = 1'b0;
            wait_cnt = rand_bits(2);
        end else if (wb_master.stb) begin
            if (wait_cnt > 0) begin
                wait_cnt--;
            end else begin
                wb_ack = 1'b1;
                if (first_adr.size() < 4) begin
                    first_adr.push_back(wb_master.adr);
                    first_we.push_back(wb_master.we);
                end
                if (wb_master.we) begin
                    mem[wb_master.adr[11:0]] = wb_master.dat;
                    if (wb_master.adr == MARKER + 3) marker_hit = 1'b1;
                end else begin
                    wb_dat_i = mem[wb_master.adr[11:0]];
                end
            end
        end
    end

    function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                           input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                           input int rd, input int opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] s_type(input int off, input int rs2, input int rs1);
        return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'b0100011}; // sw
    endfunction

    function automatic logic [31:0] b_type(input int off, input int rs2, input int rs1,
                                           input int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input int imm, input int rd, input int opc);
        return {imm[19:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] j_type(input int off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    // RV32I result of OP / OP-IMM
    function automatic logic [31:0] rv_op(input int f3, input bit alt, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            0: return alt ? a - b : a + b;
            1: return a << b[4:0];
            2: return {31'b0, $signed(a) < $signed(b)};
            3: return {31'b0, a < b};
            4: return a ^ b;
            5: begin
                if (alt) return $unsigned($signed(a) >>> b[4:0]);
                return a >> b[4:0];
            end
            6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [7:0] fill_byte(input logic [11:0] a);
        return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'ha5;
    endfunction

    function automatic logic [31:0] word_at(input int addr);
        logic [11:0] a;
        a = 12'(addr);
        return {mem[a + 12'd3], mem[a + 12'd2], mem[a + 12'd1], mem[a]};
    endfunction

    function automatic int here();
        return `CPU_RESET_VECTOR + prog.size() * 4; // pc of the next emitted word
    endfunction

    task automatic emit(input logic [31:0] w);
        prog.push_back(w);
    endtask

    task automatic li_word(input int rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = v + 32'h800; // addi sign-extends the low part
        emit(u_type(hi >> 12, rd, OPC_LUI));
        emit(i_type(v, rd, 0, rd, OPC_OP_IMM));
    endtask

    task automatic load_program();
        emit(s_type(MARKER, 0, 0));
        emit(j_type(0, 0)); // park
        for (int a = 0; a < MEM_SIZE; a++) mem[12'(a)] = fill_byte(12'(a));
        for (int i = 0; i < prog.size(); i++) begin
            for (int j = 0; j < 4; j++) begin
                mem[12'(`CPU_RESET_VECTOR + 4 * i + j)] = prog[i][8 * j +: 8];
            end
        end
        marker_hit = 1'b0;
        first_adr.delete();
        first_we.delete();
    endtask

    task automatic run_program(input string name);
        int cycles;
        @(negedge clk);
        reset = 1'b1;
        load_program();
        repeat (10) @(negedge clk);
        expect_value("wb_master.cyc", {31'b0, wb_master.cyc}, 32'h0);
        expect_value("wb_master.stb", {31'b0, wb_master.stb}, 32'h0);
        reset  = 1'b0;
        cycles = 0;
        while (!marker_hit && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!marker_hit) begin
            timeouts++;
            $display("timeout: program %s never reached its final store", name);
        end
    endtask

    task automatic expect_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("ERROR %s: expected %h, got %h", what, exp, got);
        end
    endtask

    task automatic expect_mem(input int addr, input logic [31:0] exp);
        expect_value($sformatf("mem[%03h]", addr), word_at(addr), exp);
    endtask

    task automatic reset_fetch_order();
        prog.delete();
        run_program("reset_fetch_order");
        assert (first_adr.size() == 4) else begin
            errors++;
            $display("fewer than four bus bytes seen after reset");
        end
        for (int i = 0; i < first_adr.size(); i++) begin
            expect_value("wb_master.adr", first_adr[i], `CPU_RESET_VECTOR + i);
            expect_value("wb_master.we", {31'b0, first_we[i]}, 32'h0);
        end
    endtask

    task automatic arith_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] exp [20];
        int          n;
        prog.delete();
        a = rand_bits(32);
        b = rand_bits(32);
        li_word(1, a);
        li_word(2, b);
        n = 0;
        for (int k = 0; k < 10; k++) begin
            emit(r_type(op_alt[k] ? 'h20 : 0, 2, 1, op_f3[k], 3));
            emit(s_type(RESULTS + 4 * n, 3, 0));
            exp[n] = rv_op(op_f3[k], op_alt[k], a, b);
            n++;
        end
        for (int k = 0; k < 10; k++) begin
            if (k == 1) continue; // no subi
            if (op_f3[k] == 1 || op_f3[k] == 5) begin
                imm = rand_bits(5);
                if (op_alt[k]) imm[10] = 1'b1;
            end else begin
                imm = rand_bits(12);
            end
            emit(i_type(imm, 1, op_f3[k], 3, OPC_OP_IMM));
            emit(s_type(RESULTS + 4 * n, 3, 0));
            exp[n] = rv_op(op_f3[k], op_alt[k], a, {{20{imm[11]}}, imm[11:0]});
            n++;
        end
        emit(r_type(0, 2, 1, 0, 0));           // writes to x0 are lost
        emit(i_type(5, 1, 0, 0, OPC_OP_IMM));
        emit(s_type(RESULTS + 4 * n, 0, 0));
        exp[n] = '0;
        n++;
        run_program("arith_ops");
        for (int i = 0; i < n; i++) expect_mem(RESULTS + 4 * i, exp[i]);
    endtask

    task automatic store_load_word();
        logic [31:0] d;
        int          base;
        prog.delete();
        d    = rand_bits(32);
        base = 'h100 + 16 * rand_bits(3);
        li_word(1, d);
        emit(i_type(base, 0, 0, 2, OPC_OP_IMM));
        emit(s_type(8, 1, 2));
        emit(i_type(8, 2, 2, 3, OPC_LOAD)); // lw x3, 8(x2)
        emit(s_type(RESULTS, 3, 0));
        run_program("store_load_word");
        for (int i = 0; i < 4; i++) begin
            expect_value($sformatf("mem[%03h]", base + 8 + i), {24'h0, mem[12'(base + 8 + i)]},
                         {24'h0, d[8 * i +: 8]});
        end
        expect_mem(RESULTS, d);
    endtask

    task automatic branch_loops();
        int n;
        int m;
        int loop_at;
        prog.delete();
        n = rand_bits(3) + 1;
        m = rand_bits(2) + 2;
        emit(i_type(n, 0, 0, 1, OPC_OP_IMM));
        emit(i_type(0, 0, 0, 2, OPC_OP_IMM));
        loop_at = here();
        emit(i_type(1, 2, 0, 2, OPC_OP_IMM));
        emit(i_type(-1, 1, 0, 1, OPC_OP_IMM));
        emit(b_type(loop_at - here(), 0, 1, 1)); // bne x1, x0
        emit(i_type(-m, 0, 0, 3, OPC_OP_IMM));
        emit(i_type(0, 0, 0, 4, OPC_OP_IMM));
        loop_at = here();
        emit(i_type(3, 4, 0, 4, OPC_OP_IMM));
        emit(i_type(1, 3, 0, 3, OPC_OP_IMM));
        emit(b_type(loop_at - here(), 0, 3, 4)); // blt x3, x0
        emit(i_type(7, 0, 0, 5, OPC_OP_IMM));
        emit(b_type(8, 0, 5, 0));                // beq x5, x0 not taken
        emit(i_type(1, 5, 0, 5, OPC_OP_IMM));
        emit(s_type(RESULTS, 2, 0));
        emit(s_type(RESULTS + 4, 4, 0));
        emit(s_type(RESULTS + 8, 5, 0));
        run_program("branch_loops");
        expect_mem(RESULTS, n);
        expect_mem(RESULTS + 4, 3 * m);
        expect_mem(RESULTS + 8, 8);
    endtask

    task automatic jump_and_upper();
        logic [31:0] exp [6];
        logic [31:0] up;
        logic [31:0] up2;
        int          target;
        prog.delete();
        emit(i_type(0, 0, 0, 6, OPC_OP_IMM));
        exp[0] = here() + 4;
        emit(j_type(12, 1));
        emit(i_type(1, 0, 0, 6, OPC_OP_IMM)); // skipped
        emit(i_type(1, 0, 0, 6, OPC_OP_IMM));
        emit(i_type('h55, 0, 0, 7, OPC_OP_IMM));
        target = here() + 12;
        emit(i_type(target, 0, 0, 8, OPC_OP_IMM));
        exp[3] = here() + 4;
        emit(i_type(1, 8, 0, 9, OPC_JALR));   // bit 0 of the target is dropped
        emit(i_type(2, 0, 0, 6, OPC_OP_IMM));
        up  = rand_bits(20);
        up2 = rand_bits(20);
        emit(u_type(up, 10, OPC_LUI));
        exp[5] = here() + (up2 << 12);
        emit(u_type(up2, 11, OPC_AUIPC));
        exp[1] = '0;
        exp[2] = 'h55;
        exp[4] = up << 12;
        emit(s_type(RESULTS, 1, 0));
        emit(s_type(RESULTS + 4, 6, 0));
        emit(s_type(RESULTS + 8, 7, 0));
        emit(s_type(RESULTS + 12, 9, 0));
        emit(s_type(RESULTS + 16, 10, 0));
        emit(s_type(RESULTS + 20, 11, 0));
        run_program("jump_and_upper");
        for (int i = 0; i < 6; i++) expect_mem(RESULTS + 4 * i, exp[i]);
    endtask

    initial begin
        reset_fetch_order();
        arith_ops();
        store_load_word();
        branch_loops();
        jump_and_upper();
        $display("failed checks: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu (
    input  wire logic                  clk,
    input  wire logic                  reset,
    output cpu_pkg::wb_master_t        wb_master,
    input  wire logic                  wb_ack,
    input  wire logic [`CPU_BUS_W-1:0] wb_dat_i
);

    cpu_pkg::decoded_t    decoded;
    cpu_pkg::alu_req_t    alu_req;
    cpu_pkg::alu_flags_t  alu_flags;
    cpu_pkg::bus_req_t    bus_req;
    logic [`CPU_XLEN-1:0] alu_result;
    logic [`CPU_XLEN-1:0] rs1_val;
    logic [`CPU_XLEN-1:0] rs2_val;
    logic [`CPU_XLEN-1:0] reg_wdata;
    logic [`CPU_XLEN-1:0] bus_rdata;
    logic                 bus_busy;
    logic                 dec_en;
    logic                 reg_re;
    logic                 reg_we;

    cpu_control control_i (
        .clk        (clk),
        .reset      (reset),
        .decoded    (decoded),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .alu_result (alu_result),
        .alu_flags  (alu_flags),
        .bus_rdata  (bus_rdata),
        .bus_busy   (bus_busy),
        .bus_req    (bus_req),
        .dec_en     (dec_en),
        .reg_re     (reg_re),
        .reg_we     (reg_we),
        .reg_wdata  (reg_wdata),
        .alu_req    (alu_req)
    );

    alu alu_i (
        .clk    (clk),
        .reset  (reset),
        .req    (alu_req),
        .result (alu_result),
        .flags  (alu_flags)
    );

    register_file regs_i (
        .clk     (clk),
        .reset   (reset),
        .re      (reg_re),
        .we      (reg_we),
        .rs1     (decoded.rs1),
        .rs2     (decoded.rs2),
        .rd      (decoded.rd),
        .wdata   (reg_wdata),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    // fetched word comes straight from the bus unit
    instr_decoder decoder_i (
        .clk     (clk),
        .reset   (reset),
        .en      (dec_en),
        .instr   (bus_rdata),
        .decoded (decoded)
    );

    bus_wb8 bus_i (
        .clk   (clk),
        .reset (reset),
        .req   (bus_req),
        .busy  (bus_busy),
        .rdata (bus_rdata),
        .wb    (wb_master),
        .ack   (wb_ack),
        .dat_i (wb_dat_i)
    );

endmodule

`default_nettype wire

//--- src/cpu_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_control (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire cpu_pkg::decoded_t     decoded,
    input  wire logic [`CPU_XLEN-1:0]  rs1_val,
    input  wire logic [`CPU_XLEN-1:0]  rs2_val,
    input  wire logic [`CPU_XLEN-1:0]  alu_result,
    input  wire cpu_pkg::alu_flags_t   alu_flags,
    input  wire logic [`CPU_XLEN-1:0]  bus_rdata,
    input  wire logic                  bus_busy,
    output cpu_pkg::bus_req_t          bus_req,
    output logic                       dec_en,
    output logic                       reg_re,
    output logic                       reg_we,
    output logic [`CPU_XLEN-1:0]       reg_wdata,
    output cpu_pkg::alu_req_t          alu_req
);

    typedef enum logic [4:0] {
        S_RESET, S_FETCH, S_FETCH_WAIT, S_DECODE, S_REGREAD,
        S_OP, S_OP_IMM, S_LUI, S_AUIPC, S_LINK, S_LINK_WB,
        S_BRANCH, S_BRANCH_RESOLVE, S_MEM_ADDR, S_MEM_START, S_MEM_WAIT,
        S_WB_ALU, S_WB_BUS, S_PC_NEXT, S_PC_IMM, S_PC_REG_IMM, S_PC_UPDATE
    } state_e;

    typedef enum logic {A_REG, A_PC} a_sel_e;
    typedef enum logic [1:0] {B_REG, B_IMM, B_LEN} b_sel_e;
    typedef enum logic [1:0] {WB_ALU, WB_BUS, WB_IMM} wb_sel_e;

    state_e               state;
    logic [`CPU_XLEN-1:0] pc;
    a_sel_e               a_sel;
    b_sel_e               b_sel;
    wb_sel_e              wb_sel;
    cpu_pkg::alu_op_e     arith_op;
    logic                 taken;
    logic                 is_store;

    assign is_store = decoded.opcode == cpu_pkg::OP_STORE;

    // funct7 bit 5 picks sub only for register operands
    always_comb begin
        case (decoded.funct3)
            cpu_pkg::F3_ADD_SUB:
                arith_op = (state == S_OP && decoded.funct7_5) ? cpu_pkg::ALU_SUB
                                                               : cpu_pkg::ALU_ADD;
            cpu_pkg::F3_SLL:  arith_op = cpu_pkg::ALU_SLL;
            cpu_pkg::F3_SLT:  arith_op = cpu_pkg::ALU_SLT;
            cpu_pkg::F3_SLTU: arith_op = cpu_pkg::ALU_SLTU;
            cpu_pkg::F3_XOR:  arith_op = cpu_pkg::ALU_XOR;
            cpu_pkg::F3_SRL_SRA:
                arith_op = decoded.funct7_5 ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
            cpu_pkg::F3_OR:   arith_op = cpu_pkg::ALU_OR;
            default:          arith_op = cpu_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        case (decoded.funct3)
            cpu_pkg::F3_BEQ:  taken = alu_flags.eq;
            cpu_pkg::F3_BNE:  taken = !alu_flags.eq;
            cpu_pkg::F3_BLT:  taken = alu_flags.lt;
            cpu_pkg::F3_BGE:  taken = !alu_flags.lt;
            cpu_pkg::F3_BLTU: taken = alu_flags.ltu;
            default:          taken = !alu_flags.ltu; // bgeu
        endcase
    end

    always_comb begin
        a_sel         = A_REG;
        b_sel         = B_IMM;
        wb_sel        = WB_ALU;
        alu_req.en    = 1'b0;
        alu_req.op    = cpu_pkg::ALU_ADD;
        bus_req.start = 1'b0;
        bus_req.write = 1'b0;
        bus_req.addr  = alu_result; // load/store address
        bus_req.wdata = rs2_val;
        dec_en        = 1'b0;
        reg_re        = 1'b0;
        reg_we        = 1'b0;
        case (state)
            S_FETCH: begin
                bus_req.start = 1'b1;
                bus_req.addr  = pc;
            end
            S_DECODE:  dec_en = 1'b1;
            S_REGREAD: reg_re = 1'b1;
            S_OP: begin
                alu_req.en = 1'b1;
                alu_req.op = arith_op;
                b_sel      = B_REG;
            end
            S_OP_IMM: begin
                alu_req.en = 1'b1;
                alu_req.op = arith_op;
            end
            S_AUIPC, S_PC_IMM: begin
                alu_req.en = 1'b1;
                a_sel      = A_PC;
            end
            S_LINK, S_PC_NEXT: begin
                alu_req.en = 1'b1;
                a_sel      = A_PC;
                b_sel      = B_LEN;
            end
            S_BRANCH: begin
                alu_req.en = 1'b1; // only the flags matter
                b_sel      = B_REG;
            end
            S_MEM_ADDR, S_PC_REG_IMM: alu_req.en = 1'b1;
            S_MEM_START: begin
                bus_req.start = 1'b1;
                bus_req.write = is_store;
            end
            S_LUI: begin
                reg_we = 1'b1;
                wb_sel = WB_IMM;
            end
            S_LINK_WB, S_WB_ALU: reg_we = 1'b1;
            S_WB_BUS: begin
                reg_we = 1'b1;
                wb_sel = WB_BUS;
            end
            default: ;
        endcase

        alu_req.a = (a_sel == A_PC) ? pc : rs1_val;
        case (b_sel)
            B_REG:   alu_req.b = rs2_val;
            B_IMM:   alu_req.b = decoded.imm;
            default: alu_req.b = `CPU_XLEN'(`CPU_INSTR_LEN);
        endcase
        case (wb_sel)
            WB_BUS:  reg_wdata = bus_rdata;
            WB_IMM:  reg_wdata = decoded.imm;
            default: reg_wdata = alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_RESET;
            pc    <= `CPU_RESET_VECTOR;
        end else begin
            case (state)
                S_RESET:      state <= S_FETCH;
                S_FETCH:      state <= S_FETCH_WAIT;
                S_FETCH_WAIT: if (!bus_busy) state <= S_DECODE;
                S_DECODE:     state <= S_REGREAD;
                S_REGREAD: begin
                    case (decoded.opcode)
                        cpu_pkg::OP_OP:       state <= S_OP;
                        cpu_pkg::OP_OP_IMM:   state <= S_OP_IMM;
                        cpu_pkg::OP_LUI:      state <= S_LUI;
                        cpu_pkg::OP_AUIPC:    state <= S_AUIPC;
                        cpu_pkg::OP_JAL,
                        cpu_pkg::OP_JALR:     state <= S_LINK;
                        cpu_pkg::OP_BRANCH:   state <= S_BRANCH;
                        cpu_pkg::OP_LOAD,
                        cpu_pkg::OP_STORE:    state <= S_MEM_ADDR;
                        cpu_pkg::OP_MISC_MEM: state <= S_PC_NEXT; // fence as nop
                        default:              state <= S_PC_NEXT;
                    endcase
                end
                S_OP, S_OP_IMM, S_AUIPC: state <= S_WB_ALU;
                S_LINK:           state <= S_LINK_WB;
                S_LINK_WB:        state <= decoded.jalr ? S_PC_REG_IMM : S_PC_IMM;
                S_BRANCH:         state <= S_BRANCH_RESOLVE;
                S_BRANCH_RESOLVE: state <= taken ? S_PC_IMM : S_PC_NEXT;
                S_MEM_ADDR:       state <= S_MEM_START;
                S_MEM_START:      state <= S_MEM_WAIT;
                S_MEM_WAIT: begin
                    if (!bus_busy) begin
                        state <= is_store ? S_PC_NEXT : S_WB_BUS;
                    end
                end
                S_LUI, S_WB_ALU, S_WB_BUS:         state <= S_PC_NEXT;
                S_PC_NEXT, S_PC_IMM, S_PC_REG_IMM: state <= S_PC_UPDATE;
                S_PC_UPDATE: begin
                    pc    <= {alu_result[`CPU_XLEN-1:1], 1'b0}; // jalr clears bit 0
                    state <= S_FETCH;
                end
                default: state <= S_RESET;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/bus_wb8.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module bus_wb8 (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire cpu_pkg::bus_req_t     req,
    output logic                       busy,
    output logic [`CPU_XLEN-1:0]       rdata,
    output cpu_pkg::wb_master_t        wb,
    input  wire logic                  ack,
    input  wire logic [`CPU_BUS_W-1:0] dat_i
);

    localparam int BYTES = `CPU_XLEN / `CPU_BUS_W;
    localparam int CNT_W = $clog2(BYTES);
    localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(BYTES - 1);

    logic [CNT_W-1:0]     byte_cnt;
    logic [`CPU_XLEN-1:0] shift;
    logic                 taken;

    assign taken = wb.stb && ack; // byte accepted this cycle
    assign rdata = shift;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            byte_cnt <= '0;
            wb       <= '0;
        end else if (req.start) begin
            busy     <= 1'b1;
            byte_cnt <= '0;
            wb.cyc   <= 1'b1;
            wb.stb   <= 1'b1;
            wb.we    <= req.write;
            wb.adr   <= req.addr;
            wb.dat   <= req.wdata[`CPU_BUS_W-1:0];
        end else if (taken) begin
            wb.stb   <= 1'b0; // one idle cycle between bytes
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == LAST_BYTE) begin
                busy   <= 1'b0;
                wb.cyc <= 1'b0;
                wb.we  <= 1'b0;
            end
        end else if (wb.cyc && !wb.stb) begin
            wb.stb <= 1'b1;
            wb.adr <= wb.adr + 1'b1;
            wb.dat <= shift[`CPU_BUS_W-1:0];
        end
    end

    // write bytes leave at the bottom, read bytes enter at the top
    always_ff @(posedge clk) begin
        if (req.start) begin
            shift <= req.wdata;
        end else if (taken) begin
            shift <= {dat_i, shift[`CPU_XLEN-1:`CPU_BUS_W]};
        end
    end

endmodule

`default_nettype wire

//--- src/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module instr_decoder (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              en,
    input  wire cpu_pkg::instr_u   instr,
    output cpu_pkg::decoded_t      decoded
);

    logic [`CPU_XLEN-1:0] imm;

    // immediate layout follows the format of the opcode
    always_comb begin
        case (instr.r.opcode)
            cpu_pkg::OP_STORE:
                imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
            cpu_pkg::OP_BRANCH:
                imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                       instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            cpu_pkg::OP_LUI, cpu_pkg::OP_AUIPC:
                imm = {instr.u.imm_31_12, 12'b0};
            cpu_pkg::OP_JAL:
                imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                       instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            default:
                imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0}; // I type
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded <= '0;
        end else if (en) begin
            decoded.opcode   <= instr.r.opcode;
            decoded.rd       <= instr.r.rd;
            decoded.rs1      <= instr.r.rs1;
            decoded.rs2      <= instr.r.rs2;
            decoded.funct3   <= instr.r.funct3;
            decoded.funct7_5 <= instr.r.funct7[5]; // sub / sra select
            decoded.imm      <= imm;
            decoded.jalr     <= instr.r.opcode == cpu_pkg::OP_JALR;
        end
    end

endmodule

`default_nettype wire

//--- src/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module register_file (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       re,
    input  wire logic                       we,
    input  wire logic [`CPU_REG_ADDR_W-1:0] rs1,
    input  wire logic [`CPU_REG_ADDR_W-1:0] rs2,
    input  wire logic [`CPU_REG_ADDR_W-1:0] rd,
    input  wire logic [`CPU_XLEN-1:0]       wdata,
    output logic [`CPU_XLEN-1:0]            rs1_val,
    output logic [`CPU_XLEN-1:0]            rs2_val
);

    logic [`CPU_XLEN-1:0] regs [`CPU_REG_COUNT];

    always_ff @(posedge clk) begin
        if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 is never written, so mask it on read
    always_ff @(posedge clk) begin
        if (reset) begin
            rs1_val <= '0;
            rs2_val <= '0;
        end else if (re) begin
            rs1_val <= (rs1 == '0) ? '0 : regs[rs1];
            rs2_val <= (rs2 == '0) ? '0 : regs[rs2];
        end
    end

endmodule

`default_nettype wire

//--- src/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module alu (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire cpu_pkg::alu_req_t     req,
    output logic [`CPU_XLEN-1:0]       result,
    output cpu_pkg::alu_flags_t        flags
);

    logic [$clog2(`CPU_XLEN)-1:0] shamt;
    logic                         lt;
    logic                         ltu;

    assign shamt = req.b[$clog2(`CPU_XLEN)-1:0];
    assign lt    = $signed(req.a) < $signed(req.b);
    assign ltu   = req.a < req.b;

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            flags  <= '0;
        end else if (req.en) begin
            case (req.op)
                cpu_pkg::ALU_ADD:  result <= req.a + req.b;
                cpu_pkg::ALU_SUB:  result <= req.a - req.b;
                cpu_pkg::ALU_SLL:  result <= req.a << shamt;
                cpu_pkg::ALU_SLT:  result <= {{(`CPU_XLEN-1){1'b0}}, lt};
                cpu_pkg::ALU_SLTU: result <= {{(`CPU_XLEN-1){1'b0}}, ltu};
                cpu_pkg::ALU_XOR:  result <= req.a ^ req.b;
                cpu_pkg::ALU_SRL:  result <= req.a >> shamt;
                cpu_pkg::ALU_SRA:  result <= $signed(req.a) >>> shamt;
                cpu_pkg::ALU_OR:   result <= req.a | req.b;
                default:           result <= req.a & req.b;
            endcase
            // compares kept for branch resolution
            flags.eq  <= req.a == req.b;
            flags.lt  <= lt;
            flags.ltu <= ltu;
        end
    end

endmodule

`default_nettype wire

//--- src/cpu_pkg.sv
`default_nettype none

`include "cpu_config.svh"

package cpu_pkg;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        OP_LOAD     = 7'b0000011,
        OP_MISC_MEM = 7'b0001111,
        OP_OP_IMM   = 7'b0010011,
        OP_AUIPC    = 7'b0010111,
        OP_STORE    = 7'b0100011,
        OP_OP       = 7'b0110011,
        OP_LUI      = 7'b0110111,
        OP_BRANCH   = 7'b1100011,
        OP_JALR     = 7'b1100111,
        OP_JAL      = 7'b1101111
    } opcode_e;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'd0;
    localparam logic [2:0] F3_SLL     = 3'd1;
    localparam logic [2:0] F3_SLT     = 3'd2;
    localparam logic [2:0] F3_SLTU    = 3'd3;
    localparam logic [2:0] F3_XOR     = 3'd4;
    localparam logic [2:0] F3_SRL_SRA = 3'd5;
    localparam logic [2:0] F3_OR      = 3'd6;

    // funct3 for branches
    localparam logic [2:0] F3_BEQ  = 3'd0;
    localparam logic [2:0] F3_BNE  = 3'd1;
    localparam logic [2:0] F3_BLT  = 3'd4;
    localparam logic [2:0] F3_BGE  = 3'd5;
    localparam logic [2:0] F3_BLTU = 3'd6;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, six readings
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef struct packed {
        logic [6:0]                 opcode;
        logic [`CPU_REG_ADDR_W-1:0] rd;
        logic [`CPU_REG_ADDR_W-1:0] rs1;
        logic [`CPU_REG_ADDR_W-1:0] rs2;
        logic [2:0]                 funct3;
        logic                       funct7_5;
        logic [`CPU_XLEN-1:0]       imm;
        logic                       jalr;
    } decoded_t;

    typedef struct packed {
        logic                 en;
        alu_op_e              op;
        logic [`CPU_XLEN-1:0] a;
        logic [`CPU_XLEN-1:0] b;
    } alu_req_t;

    typedef struct packed {
        logic eq;
        logic lt;
        logic ltu;
    } alu_flags_t;

    typedef struct packed {
        logic                 start;
        logic                 write;
        logic [`CPU_XLEN-1:0] addr;
        logic [`CPU_XLEN-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`CPU_XLEN-1:0]  adr;
        logic [`CPU_BUS_W-1:0] dat;
    } wb_master_t;

endpackage

`default_nettype wire

//--- src/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// first fetch address
`define CPU_RESET_VECTOR 32'h0000_0000

// datapath word width
`define CPU_XLEN 32

// architectural registers
`define CPU_REG_COUNT 32
`define CPU_REG_ADDR_W 5

// pc step per instruction, in bytes
`define CPU_INSTR_LEN 4

// width of the external data bus
`define CPU_BUS_W 8

`endif
